/* dv/core_input.txt */
// Program length, program words, store count, then store records (address data)
// Program runs from address 0; x10 = 0x80 is the store base
0000003b
08000513 ff900093 00300113 402081b3 // alu setup, sub
00352023 4010d213 0010d293 00452223 // srai, srli
00552423 0020a333 0020b3b3 00431413 // slt, sltu, slli
006444b3 0f00f593 00752623 00952823 // xor, andi
00b52a23 abcde637 00001697 00c52c23 // lui, auipc
00d52e23 04002703 00170713 02e52023 // lw, addi
00210463 06152e23 00208463 02252223 // beq taken, not taken
00209463 06152e23 00211463 02252423 // bne
0020c463 06152e23 00114463 02252623 // blt
00115463 06152e23 0020d463 02252823 // bge
00116463 06152e23 0020e463 02252a23 // bltu
0020f463 06152e23 00117463 02252c23 // bgeu
008007ef 06152e23 02f52e23 0dc00813 // jal
001808e7 06152e23 06152e23 05152023 // jalr
00500013 04052223 0000006f          // x0, end loop
00000012
00000080 fffffff6 // 0 sub
00000084 fffffffc // 1 srai
00000088 7ffffffc // 2 srli
0000008c 00000000 // 3 sltu
00000090 00000011 // 4 slt slli xor
00000094 000000f0 // 5 andi
00000098 abcde000 // 6 lui
0000009c 00001048 // 7 auipc
000000a0 12340041 // 8 lw plus one
000000a4 00000003 // 9 beq
000000a8 00000003 // 10 bne
000000ac 00000003 // 11 blt
000000b0 00000003 // 12 bge
000000b4 00000003 // 13 bltu
000000b8 00000003 // 14 bgeu
000000bc 000000c4 // 15 jal link
000000c0 000000d4 // 16 jalr link
000000c4 00000000 // 17 x0

/* filelist.f */
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/main_control.sv
source/alu_control.sv
source/control_transfer.sv
source/ctlpath.sv
source/datapath.sv
source/rv_core.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert -f filelist.f --top-module tb_top -Mdir obj_dir -o sim_tb \
  && out="$(./obj_dir/sim_tb)" \
  && echo "$out" \
  && echo "$out" | grep -q "^Simulation PASSED$" \
  && echo "run_sim: test passed" \
  || { echo "run_sim: test failed"; exit 1; }

/* dv/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top with 64-word ROM and RAM models around rv_core.
// Program must end in a self-loop on its last word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_top;

  logic        clock;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic        dmem_re;
  logic [31:0] dmem_rdata;

  logic [31:0] input_words [0:160];
  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];
  logic [31:0] exp_addr [0:31];
  logic [31:0] exp_data [0:31];
  int          prog_len;
  int          exp_count;
  int          setup_errors;
  int          error_count;
  int          store_count;

  tb_clock_gen i_clock_gen (
    .clock  (clock),
    .arst_n (arst_n)
  );

  rv_core #(
    .reset_vector (32'h0)
  ) i_dut (
    .clock      (clock),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata)
  );

  tb_checker i_checker (
    .clock       (clock),
    .arst_n      (arst_n),
    .dmem_we     (dmem_we),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .exp_addr    (exp_addr),
    .exp_data    (exp_data),
    .exp_count   (exp_count),
    .error_count (error_count),
    .store_count (store_count)
  );

  // Fetch data first, load data once the new address has settled
  always @(posedge clock) begin
    #1;
    imem_data = rom[imem_addr[7:2]];
    #1;
    // Read data is only valid while the core asks for it
    dmem_rdata = dmem_re ? ram[dmem_addr[7:2]] : 'x;
  end

  always @(posedge clock) begin
    if (dmem_we) begin
      ram[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  task automatic load_input_file();
    int base;
    $readmemh("dv/core_input.txt", input_words);
    prog_len = int'(input_words[0]);
    if (prog_len < 1 || prog_len > 64) begin
      $display("Program length %0d in the input file is out of range", prog_len);
      setup_errors++;
      prog_len = 1;
    end
    // Unused ROM words hold a self-loop
    for (int i = 0; i < 64; i++) begin
      rom[i] = (i < prog_len) ? input_words[1 + i] : 32'h0000006f;
    end
    base = 1 + prog_len;
    exp_count = int'(input_words[base]);
    if (exp_count < 0 || exp_count > 32) begin
      $display("Store count %0d in the input file is out of range", exp_count);
      setup_errors++;
      exp_count = 0;
    end
    for (int i = 0; i < 32; i++) begin
      exp_addr[i] = (i < exp_count) ? input_words[base + 1 + 2 * i] : '0;
      exp_data[i] = (i < exp_count) ? input_words[base + 2 + 2 * i] : '0;
    end
  endtask

  initial begin
    int   cycle_count;
    int   cycle_limit;
    int   total_errors;
    logic finished;
    logic timed_out;
    imem_data    = '0;
    dmem_rdata   = '0;
    setup_errors = 0;
    cycle_count  = 0;
    finished     = 1'b0;
    timed_out    = 1'b0;
    for (int i = 0; i < 64; i++) begin
      ram[i] = 32'h1234_0000 + (i << 2);
    end
    load_input_file();
    cycle_limit = 4 * prog_len + 20;

    wait (arst_n === 1'b1);
    while (!finished) begin
      @(posedge clock);
      cycle_count++;
      if (imem_addr == 32'((prog_len - 1) * 4)) begin
        finished = 1'b1;
      end else if (cycle_count >= cycle_limit) begin
        timed_out = 1'b1;
        finished  = 1'b1;
      end
    end
    // Let the checker see the final edge
    repeat (2) @(posedge clock);

    total_errors = error_count + setup_errors;
    if (timed_out) begin
      $display("Timeout: program did not reach its final loop within %0d cycles",
               cycle_limit);
      total_errors++;
    end
    if (store_count < exp_count) begin
      $display("Too few stores: expected %0d, saw %0d", exp_count, store_count);
      total_errors++;
    end
    $display("Errors: %0d, stores seen: %0d of %0d", total_errors, store_count, exp_count);
    if (total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* dv/tb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compares data-memory writes, in order, with the expected list.
// Holds up to 32 expected stores.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_checker #(
  parameter int max_stores = 32
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        dmem_we,
  input  logic [31:0] dmem_addr,
  input  logic [31:0] dmem_wdata,
  input  logic [31:0] exp_addr [0:max_stores-1],
  input  logic [31:0] exp_data [0:max_stores-1],
  input  int          exp_count,
  output int          error_count,
  output int          store_count
);

  // Sampled on the edge where the store commits
  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      error_count <= 0;
      store_count <= 0;
    end else if (dmem_we) begin
      if (store_count >= exp_count) begin
        $display("Unexpected extra store number %0d to address %08h with data %08h",
                 store_count, dmem_addr, dmem_wdata);
        error_count <= error_count + 1;
      end else if (dmem_addr !== exp_addr[store_count] ||
                   dmem_wdata !== exp_data[store_count]) begin
        $display("[ERROR] store_%0d: expected addr %08h data %08h, actual addr %08h data %08h",
                 store_count, exp_addr[store_count], exp_data[store_count],
                 dmem_addr, dmem_wdata);
        error_count <= error_count + 1;
      end
      store_count <= store_count + 1;
    end
  end

endmodule

/* dv/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running clock and power-on reset for the testbench.
// Reset releases 1 ns after the last reset edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int half_period  = 50,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    arst_n = 1'b1;
  end

endmodule

/* source/rv_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle RV32I subset core that runs one instruction per clock.
// Memories must be combinational; stores commit on the clock edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_core #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_vector = '0
) (
  input  logic                         clock,
  input  logic                         arst_n,
  output logic [rv_isa_pkg::xlen-1:0] imem_addr,
  input  logic [31:0]                  imem_data,
  output logic [rv_isa_pkg::xlen-1:0] dmem_addr,
  output logic [rv_isa_pkg::xlen-1:0] dmem_wdata,
  output logic                         dmem_we,
  output logic                         dmem_re,
  input  logic [rv_isa_pkg::xlen-1:0] dmem_rdata
);
  import rv_ctrl_pkg::*;

  ctrl_t       ctrl;
  logic [31:0] inst;
  logic        alu_result_equal_zero;
  logic        run;

  ctlpath i_ctlpath (
    .clock                 (clock),
    .arst_n                (arst_n),
    .inst                  (inst),
    .alu_result_equal_zero (alu_result_equal_zero),
    .run                   (run),
    .ctrl                  (ctrl)
  );

  datapath #(
    .reset_vector (reset_vector)
  ) i_datapath (
    .clock                 (clock),
    .arst_n                (arst_n),
    .ctrl                  (ctrl),
    .inst                  (inst),
    .imem_addr             (imem_addr),
    .imem_data             (imem_data),
    .alu_result_equal_zero (alu_result_equal_zero),
    .run                   (run),
    .dmem_addr             (dmem_addr),
    .dmem_wdata            (dmem_wdata),
    .dmem_we               (dmem_we),
    .dmem_re               (dmem_re),
    .dmem_rdata            (dmem_rdata)
  );

endmodule

/* source/datapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle datapath; memories answer in the same cycle.
// Nothing commits until one edge after reset release (run flag).
// Register file has no reset, so x1..x31 start unknown.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module datapath #(
  parameter logic [rv_isa_pkg::xlen-1:0] reset_vector = '0
) (
  input  logic                         clock,
  input  logic                         arst_n,
  input  rv_ctrl_pkg::ctrl_t           ctrl,
  output logic [31:0]                  inst,
  output logic [rv_isa_pkg::xlen-1:0] imem_addr,
  input  logic [31:0]                  imem_data,
  output logic                         alu_result_equal_zero,
  output logic                         run,
  output logic [rv_isa_pkg::xlen-1:0] dmem_addr,
  output logic [rv_isa_pkg::xlen-1:0] dmem_wdata,
  output logic                         dmem_we,
  output logic                         dmem_re,
  input  logic [rv_isa_pkg::xlen-1:0] dmem_rdata
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] regs [1:31];
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_op;
  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] wb_data;

  assign imem_addr = pc;
  assign inst      = imem_data;
  assign rs1       = inst[19:15];
  assign rs2       = inst[24:20];
  assign rd        = inst[11:7];

  // Immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode_e'(inst[6:0]))
      OP_STORE:        imm_op = imm_s;
      OP_LUI, OP_AUIPC: imm_op = imm_u;
      default:         imm_op = imm_i;
    endcase
  end

  // x0 is hardwired
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  assign opa = (ctrl.opa_sel == OPA_PC) ? pc : rs1_data;
  assign opb = (ctrl.opb_sel == OPB_IMM) ? imm_op : rs2_data;

  always_comb begin
    case (ctrl.alu_function)
      ALU_ADD:    alu_result = opa + opb;
      ALU_SUB:    alu_result = opa - opb;
      ALU_SLL:    alu_result = opa << opb[4:0];
      ALU_SLT:    alu_result = {31'b0, $signed(opa) < $signed(opb)};
      ALU_SLTU:   alu_result = {31'b0, opa < opb};
      ALU_XOR:    alu_result = opa ^ opb;
      ALU_SRL:    alu_result = opa >> opb[4:0];
      ALU_SRA:    alu_result = $unsigned($signed(opa) >>> opb[4:0]);
      ALU_OR:     alu_result = opa | opb;
      ALU_AND:    alu_result = opa & opb;
      ALU_PASS_B: alu_result = opb;
      default:    alu_result = opa + opb;
    endcase
  end

  assign alu_result_equal_zero = (alu_result == '0);

  // Data memory port
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = ctrl.mem_write & run;
  assign dmem_re    = ctrl.mem_read;

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = dmem_rdata;
      WB_PC4:  wb_data = pc_plus4;
      WB_IMM:  wb_data = imm_u;
      default: wb_data = alu_result;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctrl.next_pc)
      NPC_BRANCH: next_pc = pc + imm_b;
      NPC_JAL:    next_pc = pc + imm_j;
      NPC_JALR:   next_pc = {alu_result[xlen-1:1], 1'b0};
      default:    next_pc = pc_plus4;
    endcase
  end

  // Run flag holds off the first commit by one edge
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
      pc  <= reset_vector;
    end else begin
      run <= 1'b1;
      if (run) begin
        pc <= next_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (run && ctrl.reg_write && rd != 5'd0) begin
      regs[rd] <= wb_data;
    end
  end

  a_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    run |=> pc[1:0] == 2'b00);

endmodule

/* source/ctlpath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational control path; clock and reset feed the checks only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ctlpath (
  input  logic               clock,
  input  logic               arst_n,
  input  logic [31:0]        inst,
  input  logic               alu_result_equal_zero,
  input  logic               run,
  output rv_ctrl_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_e inst_opcode;
  logic    take_branch;
  ctrl_t   ctrl_base;
  alu_op_e alu_op_type;
  alu_fn_e alu_function;

  assign inst_opcode = opcode_e'(inst[6:0]);

  main_control i_main_control (
    .inst_opcode (inst_opcode),
    .take_branch (take_branch),
    .ctrl_base   (ctrl_base),
    .alu_op_type (alu_op_type)
  );

  alu_control i_alu_control (
    .alu_op_type  (alu_op_type),
    .inst_funct3  (inst[14:12]),
    .inst_funct7  (inst[31:25]),
    .alu_function (alu_function)
  );

  control_transfer i_control_transfer (
    .inst_funct3       (branch_f3_e'(inst[14:12])),
    .result_equal_zero (alu_result_equal_zero),
    .take_branch       (take_branch)
  );

  // Merge ALU function into the decoded bundle
  always_comb begin
    ctrl              = ctrl_base;
    ctrl.alu_function = alu_function;
  end

  a_mem_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
    run |-> !(ctrl.mem_read && ctrl.mem_write));

  // Program must stay within the supported subset
  a_known_opcode: assert property (@(posedge clock) disable iff (!arst_n)
    run |-> inst_opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
                                OP_LOAD, OP_STORE, OP_IMM, OP_REG});

endmodule

/* source/control_transfer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch decision from funct3 and one zero flag.
// Relies on SUB/SLT/SLTU being chosen by alu_control.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module control_transfer (
  input  rv_isa_pkg::branch_f3_e inst_funct3,
  input  logic                   result_equal_zero,
  output logic                   take_branch
);
  import rv_isa_pkg::*;

  always_comb begin
    case (inst_funct3)
      // SUB result
      BEQ:        take_branch = result_equal_zero;
      BNE:        take_branch = !result_equal_zero;
      // SLT / SLTU result is 1 when less than
      BLT, BLTU:  take_branch = !result_equal_zero;
      BGE, BGEU:  take_branch = result_equal_zero;
      default:    take_branch = 1'b0;
    endcase
  end

endmodule

/* source/alu_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational ALU function decoder.
// Only funct7[5] is looked at; other funct7 bits are ignored.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module alu_control (
  input  rv_ctrl_pkg::alu_op_e alu_op_type,
  input  logic [2:0]           inst_funct3,
  input  logic [6:0]           inst_funct7,
  output rv_ctrl_pkg::alu_fn_e alu_function
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic alt_fn;

  // SUB only exists in register form, SRA in both
  assign alt_fn = inst_funct7[5];

  always_comb begin
    alu_function = ALU_ADD;
    case (alu_op_type)
      ALUOP_ADD: alu_function = ALU_ADD;
      ALUOP_BRANCH: begin
        // Compare result is tested against zero in control_transfer
        case (branch_f3_e'(inst_funct3))
          BEQ, BNE:   alu_function = ALU_SUB;
          BLT, BGE:   alu_function = ALU_SLT;
          BLTU, BGEU: alu_function = ALU_SLTU;
          default:    alu_function = ALU_SUB;
        endcase
      end
      default: begin
        case (alu_f3_e'(inst_funct3))
          F3_ADD_SUB: alu_function = (alu_op_type == ALUOP_REG && alt_fn) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_function = ALU_SLL;
          F3_SLT:     alu_function = ALU_SLT;
          F3_SLTU:    alu_function = ALU_SLTU;
          F3_XOR:     alu_function = ALU_XOR;
          F3_SRL_SRA: alu_function = alt_fn ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_function = ALU_OR;
          F3_AND:     alu_function = ALU_AND;
          default:    alu_function = ALU_ADD;
        endcase
      end
    endcase
  end

endmodule

/* source/main_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational main decoder.
// alu_function is left zero here; ctlpath fills it in.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module main_control (
  input  rv_isa_pkg::opcode_e  inst_opcode,
  input  logic                 take_branch,
  output rv_ctrl_pkg::ctrl_t   ctrl_base,
  output rv_ctrl_pkg::alu_op_e alu_op_type
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  always_comb begin
    // Unknown opcodes fall through with every write disabled
    ctrl_base   = '0;
    alu_op_type = ALUOP_ADD;

    case (inst_opcode)
      OP_LUI: begin
        ctrl_base.reg_write = 1'b1;
        ctrl_base.wb_sel    = WB_IMM;
      end
      OP_AUIPC: begin
        ctrl_base.opa_sel   = OPA_PC;
        ctrl_base.opb_sel   = OPB_IMM;
        ctrl_base.reg_write = 1'b1;
      end
      OP_JAL: begin
        ctrl_base.reg_write = 1'b1;
        ctrl_base.wb_sel    = WB_PC4;
        ctrl_base.next_pc   = NPC_JAL;
      end
      OP_JALR: begin
        // Target comes out of the ALU as rs1 + imm
        ctrl_base.opb_sel   = OPB_IMM;
        ctrl_base.reg_write = 1'b1;
        ctrl_base.wb_sel    = WB_PC4;
        ctrl_base.next_pc   = NPC_JALR;
      end
      OP_BRANCH: begin
        alu_op_type       = ALUOP_BRANCH;
        ctrl_base.next_pc = take_branch ? NPC_BRANCH : NPC_PC4;
      end
      OP_LOAD: begin
        ctrl_base.opb_sel   = OPB_IMM;
        ctrl_base.mem_read  = 1'b1;
        ctrl_base.reg_write = 1'b1;
        ctrl_base.wb_sel    = WB_MEM;
      end
      OP_STORE: begin
        ctrl_base.opb_sel   = OPB_IMM;
        ctrl_base.mem_write = 1'b1;
      end
      OP_IMM: begin
        alu_op_type         = ALUOP_IMM;
        ctrl_base.opb_sel   = OPB_IMM;
        ctrl_base.reg_write = 1'b1;
      end
      OP_REG: begin
        alu_op_type         = ALUOP_REG;
        ctrl_base.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* source/rv_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control encodings between control path and datapath.
// Zero in every field is the safe default (no writes, PC+4).
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SLT    = 5'd3,
    ALU_SLTU   = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_OR     = 5'd8,
    ALU_AND    = 5'd9,
    ALU_PASS_B = 5'd10
  } alu_fn_e;

  // Operation class handed from main decoder to ALU decoder
  typedef enum logic [1:0] {ALUOP_ADD, ALUOP_BRANCH, ALUOP_IMM, ALUOP_REG} alu_op_e;

  typedef enum logic {OPA_REG, OPA_PC} opa_sel_e;
  typedef enum logic {OPB_REG, OPB_IMM} opb_sel_e;

  typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

  typedef enum logic [1:0] {NPC_PC4, NPC_BRANCH, NPC_JAL, NPC_JALR} next_pc_e;

  // Decoded control bundle of 15 bits
  typedef struct packed {
    alu_fn_e  alu_function;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    wb_sel_e  wb_sel;
    next_pc_e next_pc;
  } ctrl_t;

endpackage

/* source/rv_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction encodings for the supported subset.
// Only word loads and stores; no SYSTEM or FENCE opcodes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_isa_pkg;

  // Data word width
  parameter int xlen = 32;

  // Major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  // Conditional branch funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

  // Integer ALU funct3 shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } alu_f3_e;

endpackage
